//--- verilog.f
+incdir+source
source/fog_pkg.sv
source/mod_timer.sv
source/err_demod.sv
source/ramp_integrator.sv
source/fog_loop_top.sv
testbench/tb_fog_loop.sv

//--- Makefile
# Verilator build and run of the fog loop testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_fog_loop
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= TB PASSED

SOURCES := $(wildcard source/*.sv source/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_fog_loop.sv
// self-checking testbench of the fog loop that runs as the top module of the verilator build
module tb_fog_loop import fog_pkg::*; ();

	localparam int HALF_SHORT = 64;
	localparam int HALF_LONG  = 1100;
	// every error needs two half periods and four leave room for restarts
	localparam int WATCHDOG_CYCLES = (20 + 20 + 12 + 40 + 4) * 4 * HALF_SHORT
		+ 6 * 4 * HALF_LONG + 4000;

	logic      i_clk = 1'b0;
	logic      i_rst_n;
	logic      i_status;
	cnt_t      i_half_period;
	loop_cfg_t i_cfg;
	adc_t      i_adc = '0;
	logic      o_mod_high;
	err_t      o_err;
	sync_t     o_sync;
	err_t      o_rate;
	dac_t      o_ramp;

	// adc model state
	logic mod_seen = 1'b0;
	logic big_mode = 1'b0;
	adc_t lo_const = '0;
	adc_t hi_const = '0;

	// integrator model
	err_t       model_step = '0;
	err_t       model_rate = '0;
	dac_t       model_ramp = '0;
	logic       chk_rate = 1'b0;
	logic       chk_ramp = 1'b0;
	logic [3:0] prev_sync = 4'b0;

	fog_loop_top dut0 (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_status      (i_status),
		.i_half_period (i_half_period),
		.i_cfg         (i_cfg),
		.i_adc         (i_adc),
		.o_mod_high    (o_mod_high),
		.o_err         (o_err),
		.o_sync        (o_sync),
		.o_rate        (o_rate),
		.o_ramp        (o_ramp)
	);

	always #2 i_clk = ~i_clk;

	task automatic check_val(input string name, input longint got, input longint exp);
		if (got != exp) begin
			$display("FAILED time=%0t %s: got %0d, expected %0d", $time, name, got, exp);
			$display("TB FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// average of a constant half equals the constant
	function automatic err_t expected_error(input adc_t lo, input adc_t hi, input err_t offset,
		input logic pol);
		err_t avg_lo;
		err_t avg_hi;
		avg_lo = err_t'(lo);
		avg_hi = err_t'(hi) + offset;
		if (pol) begin
			return avg_lo - avg_hi;
		end else begin
			return avg_hi - avg_lo;
		end
	endfunction

	// large mode pushes the halves apart so the ramp overflows quickly
	function automatic adc_t pick_adc(input logic high);
		if (!big_mode) begin
			return adc_t'($urandom);
		end else if (high) begin
			return adc_t'(28000 + $urandom_range(0, 4000));
		end else begin
			return adc_t'(-28000 - int'($urandom_range(0, 4000)));
		end
	endfunction

	// new constant for each half from the cycle after the level change
	always @(posedge i_clk) begin : adc_model
		adc_t v;
		if (o_mod_high != mod_seen) begin
			mod_seen <= o_mod_high;
			v = pick_adc(o_mod_high);
			if (o_mod_high) begin
				hi_const <= v;
			end else begin
				lo_const <= v;
			end
			i_adc <= v;
		end
	end

	always @(posedge i_clk) begin : compare
		err_t exp_err;
		if (i_rst_n) begin
			// updates show one cycle after their strobe
			if (chk_rate) begin
				check_val("o_rate", longint'(o_rate), longint'(model_rate));
				chk_rate = 1'b0;
			end
			if (chk_ramp) begin
				check_val("o_ramp", longint'(o_ramp), longint'(model_ramp));
				chk_ramp = 1'b0;
			end
			// step, step_dly, rate, ramp in consecutive single cycles
			if (prev_sync != 4'b0) begin
				check_val("o_sync", longint'(o_sync), longint'(prev_sync >> 1));
			end else if (o_sync != 4'b0) begin
				check_val("o_sync", longint'(o_sync), longint'(4'b1000));
			end
			if (o_sync.step) begin
				exp_err = expected_error(lo_const, hi_const, i_cfg.err_offset, i_cfg.polarity);
				check_val("o_err", longint'(o_err), longint'(exp_err));
				model_step = model_step + exp_err;
			end
			if (o_sync.rate) begin
				model_rate = model_step;
				chk_rate = 1'b1;
			end
			if (o_sync.ramp) begin
				model_ramp = model_ramp + dac_t'(model_step);
				chk_ramp = 1'b1;
			end
			prev_sync = o_sync;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge i_clk);
		$display("watchdog expired before all tests finished");
		$display("TB FAILED");
		$fatal(1, "timeout");
	end

	task automatic start_loop(input logic pol, input logic [3:0] sel, input err_t off,
		input int half);
		repeat (8) @(posedge i_clk);
		i_cfg.polarity   <= pol;
		i_cfg.avg_sel    <= sel;
		i_cfg.wait_cnt   <= cnt_t'(8);
		i_cfg.err_offset <= off;
		i_half_period    <= cnt_t'(half);
		i_status         <= 1'b1;
	endtask

	// stop right after a ramp strobe so no acquisition is cut short
	task automatic run_and_stop(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(posedge i_clk);
			if (o_sync.ramp) begin
				seen++;
			end
		end
		i_status <= 1'b0;
	endtask

	task automatic wait_mod_toggle(output int cycles);
		logic start_level;
		start_level = o_mod_high;
		cycles = 0;
		do begin
			@(posedge i_clk);
			cycles++;
		end while (o_mod_high == start_level);
	endtask

	initial begin : main
		int cycles;
		void'($urandom(32'h3892));
		i_rst_n       <= 1'b0;
		i_status      <= 1'b0;
		i_half_period <= cnt_t'(HALF_SHORT);
		i_cfg         <= '0;
		repeat (10) @(posedge i_clk);
		i_rst_n <= 1'b1;

		// loop disabled so nothing may move
		repeat (200) begin
			@(posedge i_clk);
			check_val("o_mod_high", longint'(o_mod_high), 0);
			check_val("o_sync", longint'(o_sync), 0);
		end

		// first low half includes the start cycle so only later halves are measured
		start_loop(1'b0, 4'd3, '0, HALF_SHORT);
		wait_mod_toggle(cycles);
		repeat (3) begin
			wait_mod_toggle(cycles);
			check_val("o_mod_high half period", longint'(cycles), longint'(HALF_SHORT));
		end
		run_and_stop(20);

		// reversed polarity with random offsets
		repeat (4) begin
			start_loop(1'b1, 4'd3, err_t'($urandom_range(0, 2000)) - err_t'(1000), HALF_SHORT);
			run_and_stop(5);
		end

		// average lengths with 12 clamped to 10
		start_loop(1'b0, 4'd0, '0, HALF_SHORT);
		run_and_stop(6);
		start_loop(1'b0, 4'd5, '0, HALF_SHORT);
		run_and_stop(6);
		start_loop(1'b0, 4'd12, '0, HALF_LONG);
		run_and_stop(6);

		big_mode = 1'b1;
		start_loop(1'b0, 4'd3, '0, HALF_SHORT);
		run_and_stop(40);
		repeat (8) @(posedge i_clk);

		$display("TB PASSED");
		$finish;
	end

endmodule

//--- source/fog_loop_top.sv
// top of the fog closed loop, ties the modulation timer, error demodulator and ramp integrator together
module fog_loop_top import fog_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_status,
	input  cnt_t      i_half_period,
	input  loop_cfg_t i_cfg,
	input  adc_t      i_adc,
	output logic      o_mod_high,
	output err_t      o_err,
	output sync_t     o_sync,
	output err_t      o_rate,
	output dac_t      o_ramp
);

	// half-period boundary pulse
	logic trig;

	mod_timer u_mod_timer (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_status      (i_status),
		.i_half_period (i_half_period),
		.o_mod_high    (o_mod_high),
		.o_trig        (trig)
	);

	err_demod u_err_demod (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_status (i_status),
		.i_trig   (trig),
		.i_cfg    (i_cfg),
		.i_adc    (i_adc),
		.o_err    (o_err),
		.o_sync   (o_sync)
	);

	// integrator reads the same error and strobes that leave the top
	ramp_integrator u_ramp_integrator (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_err   (o_err),
		.i_sync  (o_sync),
		.o_rate  (o_rate),
		.o_ramp  (o_ramp)
	);

endmodule

//--- source/ramp_integrator.sv
// ramp integrator, turns the demodulated error into step, rate and the wrapping feedback ramp
`include "fog_params.svh"

module ramp_integrator import fog_pkg::*; (
	input  logic  i_clk,
	input  logic  i_rst_n,
	input  err_t  i_err,
	input  sync_t i_sync,
	output err_t  o_rate,
	output dac_t  o_ramp
);

	err_t r_step;
	logic r_step_dly_d;
	err_t step_next;
	err_t step_cur;
	dac_t ramp_inc;

	assign step_next = r_step + i_err;

	// step value including an update landing this cycle
	assign step_cur = r_step_dly_d ? step_next : r_step;

	// only the low dac bits feed the ramp
	assign ramp_inc = r_step[`FOG_DAC_BITS-1:0];

	// error is settled by the cycle after step_dly
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_step_dly_d <= 1'b0;
		end else begin
			r_step_dly_d <= i_sync.step_dly;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_step <= '0;
		end else if (r_step_dly_d) begin
			r_step <= step_next;
		end
	end

	// rate coincides with the step update, so latch the updated value
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_rate <= '0;
		end else if (i_sync.rate) begin
			o_rate <= step_cur;
		end
	end

	// modulo 2^dac_bits, overflow wraps
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ramp <= '0;
		end else if (i_sync.ramp) begin
			o_ramp <= o_ramp + ramp_inc;
		end
	end

endmodule

//--- source/err_demod.sv
// error demodulator, averages the low and high half samples after settling and sequences the sync strobes
`include "fog_params.svh"

module err_demod import fog_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_status,
	input  logic      i_trig,
	input  loop_cfg_t i_cfg,
	input  adc_t      i_adc,
	output err_t      o_err,
	output sync_t     o_sync
);

	localparam logic [3:0] AVG_SEL_MAX = 4'(`FOG_AVG_SEL_MAX);

	demod_state_e r_state;
	demod_state_e nstate;

	// registered inputs
	logic      r_status;
	logic      r_trig;
	loop_cfg_t r_cfg;
	adc_t      r_adc;

	cnt_t       r_settle_cnt;
	cnt_t       r_avg_cnt;
	logic [3:0] r_shift;
	err_t       r_sum;
	err_t       r_avg_l;
	err_t       r_avg_h;

	logic [3:0] sel_clamp;
	cnt_t       avg_len;
	err_t       sum_next;
	err_t       avg_new;
	err_t       err_next;
	logic       settle_done;
	logic       acq_done;
	logic       half_start;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_status <= 1'b0;
			r_trig   <= 1'b0;
		end else begin
			r_status <= i_status;
			r_trig   <= i_trig;
		end
	end

	always_ff @(posedge i_clk) begin
		r_cfg <= i_cfg;
		r_adc <= i_adc;
	end

	always_comb begin
		if (r_cfg.avg_sel > AVG_SEL_MAX) begin
			sel_clamp = AVG_SEL_MAX;
		end else begin
			sel_clamp = r_cfg.avg_sel;
		end
	end

	assign avg_len     = cnt_t'(1) << sel_clamp;
	// sample is sign extended into the sum
	assign sum_next    = r_sum + err_t'(r_adc);
	assign avg_new     = sum_next >>> r_shift;
	assign err_next    = r_cfg.polarity ? (r_avg_l - r_avg_h) : (r_avg_h - r_avg_l);
	assign settle_done = (r_settle_cnt == '0);
	assign acq_done    = (r_avg_cnt == cnt_t'(1));
	// triggers outside the two wait states are dropped
	assign half_start  = r_trig && ((r_state == DM_WAIT_L) || (r_state == DM_WAIT_H));

	always_comb begin
		nstate = r_state;
		case (r_state)
			DM_IDLE: begin
				if (r_status) begin
					nstate = DM_WAIT_L;
				end
			end
			DM_WAIT_L: begin
				if (!r_status) begin
					nstate = DM_IDLE;
				end else if (r_trig) begin
					nstate = DM_SETTLE_L;
				end
			end
			DM_SETTLE_L: begin
				if (settle_done) begin
					nstate = DM_ACQ_L;
				end
			end
			DM_ACQ_L: begin
				if (acq_done) begin
					nstate = DM_WAIT_H;
				end
			end
			DM_WAIT_H: begin
				if (!r_status) begin
					nstate = DM_IDLE;
				end else if (r_trig) begin
					nstate = DM_SETTLE_H;
				end
			end
			DM_SETTLE_H: begin
				if (settle_done) begin
					nstate = DM_ACQ_H;
				end
			end
			DM_ACQ_H: begin
				if (acq_done) begin
					nstate = DM_ERR;
				end
			end
			DM_ERR:     nstate = DM_ERR_DLY;
			DM_ERR_DLY: nstate = DM_RATE;
			DM_RATE:    nstate = DM_RAMP;
			DM_RAMP:    nstate = DM_NEXT;
			DM_NEXT:    nstate = r_status ? DM_WAIT_L : DM_IDLE;
			default:    nstate = DM_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state <= DM_IDLE;
		end else begin
			r_state <= nstate;
		end
	end

	// settle and average counters, reloaded at the start of each half
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_settle_cnt <= '0;
			r_avg_cnt    <= '0;
			r_shift      <= '0;
		end else if (half_start) begin
			r_settle_cnt <= r_cfg.wait_cnt;
			r_avg_cnt    <= avg_len;
			r_shift      <= sel_clamp;
		end else if ((r_state == DM_SETTLE_L) || (r_state == DM_SETTLE_H)) begin
			if (!settle_done) begin
				r_settle_cnt <= r_settle_cnt - cnt_t'(1);
			end
		end else if ((r_state == DM_ACQ_L) || (r_state == DM_ACQ_H)) begin
			r_avg_cnt <= r_avg_cnt - cnt_t'(1);
		end
	end

	always_ff @(posedge i_clk) begin
		if (half_start) begin
			r_sum <= '0;
		end else if ((r_state == DM_ACQ_L) || (r_state == DM_ACQ_H)) begin
			r_sum <= sum_next;
		end
		if ((r_state == DM_ACQ_L) && acq_done) begin
			r_avg_l <= avg_new;
		end
		// offset rides on the high average
		if ((r_state == DM_ACQ_H) && acq_done) begin
			r_avg_h <= avg_new + r_cfg.err_offset;
		end
	end

	// error and step come out together, then one strobe per cycle
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_err  <= '0;
			o_sync <= '0;
		end else begin
			o_sync <= '0;
			case (r_state)
				DM_ERR: begin
					o_err       <= err_next;
					o_sync.step <= 1'b1;
				end
				DM_ERR_DLY: o_sync.step_dly <= 1'b1;
				DM_RATE:    o_sync.rate     <= 1'b1;
				DM_RAMP:    o_sync.ramp     <= 1'b1;
				default: begin
				end
			endcase
		end
	end

endmodule

//--- source/mod_timer.sv
// modulation timer, splits time into low and high halves and flags each boundary to the demodulator
module mod_timer import fog_pkg::*; (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_status,
	input  cnt_t i_half_period,
	output logic o_mod_high,
	output logic o_trig
);

	cnt_t r_cnt;
	cnt_t reload;
	logic r_run;
	logic r_bound;

	// half period below 2 runs as 2
	always_comb begin
		if (i_half_period < cnt_t'(2)) begin
			reload = cnt_t'(1);
		end else begin
			reload = i_half_period - cnt_t'(1);
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_cnt      <= '0;
			r_run      <= 1'b0;
			r_bound    <= 1'b0;
			o_mod_high <= 1'b0;
		end else if (!i_status) begin
			// loop disabled, hold everything at the low level
			r_cnt      <= '0;
			r_run      <= 1'b0;
			r_bound    <= 1'b0;
			o_mod_high <= 1'b0;
		end else if (!r_run) begin
			// start of the first low half, flagged without a toggle
			r_cnt   <= reload;
			r_run   <= 1'b1;
			r_bound <= 1'b1;
		end else if (r_cnt == '0) begin
			r_cnt      <= reload;
			r_bound    <= 1'b1;
			o_mod_high <= ~o_mod_high;
		end else begin
			r_cnt   <= r_cnt - cnt_t'(1);
			r_bound <= 1'b0;
		end
	end

	// trigger lands one cycle after the level change
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_trig <= 1'b0;
		end else begin
			o_trig <= r_bound & i_status;
		end
	end

endmodule

//--- source/fog_pkg.sv
// shared types of the fog closed loop, compile before every rtl module that imports it
`include "fog_params.svh"

package fog_pkg;

	// vectors with a meaning of their own
	typedef logic signed [`FOG_ADC_BITS-1:0] adc_t;
	typedef logic signed [`FOG_ERR_BITS-1:0] err_t;
	typedef logic        [`FOG_ERR_BITS-1:0] cnt_t;
	typedef logic        [`FOG_DAC_BITS-1:0] dac_t;

	// loop setup, average length is 2^avg_sel
	typedef struct packed {
		logic       polarity;
		logic [3:0] avg_sel;
		cnt_t       wait_cnt;
		err_t       err_offset;
	} loop_cfg_t;

	// one-cycle strobes, issued in this order
	typedef struct packed {
		logic step;
		logic step_dly;
		logic rate;
		logic ramp;
	} sync_t;

	typedef enum logic [3:0] {
		DM_IDLE, DM_WAIT_L, DM_SETTLE_L, DM_ACQ_L, DM_WAIT_H, DM_SETTLE_H,
		DM_ACQ_H, DM_ERR, DM_ERR_DLY, DM_RATE, DM_RAMP, DM_NEXT
	} demod_state_e;

endpackage

//--- source/fog_params.svh
// width and limit macros for the fog loop, included by the package and by the rtl that needs them
`ifndef FOG_PARAMS_SVH
`define FOG_PARAMS_SVH

// signed adc sample
`define FOG_ADC_BITS 16

// error, step, rate, adc sum and all counters
`define FOG_ERR_BITS 32

// feedback ramp, wraps at this width
`define FOG_DAC_BITS 16

// largest average select, 2^10 samples per half
// larger requests get clamped to this
`define FOG_AVG_SEL_MAX 10

`endif
